/* bench/dft_mem_model.svh */
`ifndef DFT_MEM_MODEL_SVH
`define DFT_MEM_MODEL_SVH

// ----------------------------------------
// Reference model of the frame memory
// ----------------------------------------
// Stimulus generator state
logic [31:0]             rng_state = 32'hf448_1433;
// Radix per position, absent factors held at 1
int                      fac [0:2];
// Expected frame contents, updated stage by stage
dft_sample_pkg::sample_t model_mem [0:63];

// LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Next input sample, re and im from two draws
function automatic dft_sample_pkg::sample_t draw_sample();
	dft_sample_pkg::sample_t s;
	rng_state = lcg_next(rng_state);
	s.re = rng_state[31:16];
	rng_state = lcg_next(rng_state);
	s.im = rng_state[31:16];
	return s;
endfunction

// All stages in place, each group reversed with k+1 added to re
task automatic apply_stages(input int stages);
	dft_sample_pkg::sample_t grp [0:4];
	int n;
	int prod;
	int fs;
	int l;
	int base;
	n = fac[0] * fac[1] * fac[2];
	prod = 1;
	for (int s = 0; s < stages; s++) begin
		fs = fac[s];
		prod = prod * fs;
		// Stride is what is left of N after this stage
		l = n / prod;
		for (int blk = 0; blk < n / (fs * l); blk++) begin
			for (int j = 0; j < l; j++) begin
				base = blk * fs * l + j;
				for (int k = 0; k < fs; k++) begin
					grp[k] = model_mem[base + k * l];
				end
				for (int k = 0; k < fs; k++) begin
					model_mem[base + k * l] = grp[fs - 1 - k];
					model_mem[base + k * l].re = grp[fs - 1 - k].re + 16'(k + 1);
				end
			end
		end
	end
endtask

// Digit-reversed read address of output position m
function automatic int out_addr(input int m);
	int n;
	int d0;
	int d1;
	int d2;
	n = fac[0] * fac[1] * fac[2];
	d0 = m % fac[0];
	d1 = (m / fac[0]) % fac[1];
	d2 = m / (fac[0] * fac[1]);
	return d0 * (n / fac[0]) + d1 * (n / (fac[0] * fac[1])) + d2;
endfunction

`endif

/* bench/dft_mem_tb.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_mem_tb;

	localparam int NUM_TESTS = 7;
	// Samples sent before a truncated frame stalls
	localparam int TRUNC_LEN = 3;

	logic                      clk;
	logic                      rst_n;
	dft_sample_pkg::in_beat_t  in_beat;
	dft_plan_pkg::plan_t       plan;
	dft_sample_pkg::grp_beat_t to_core;
	dft_sample_pkg::grp_beat_t from_core;
	dft_sample_pkg::out_beat_t out_beat;
	logic                      sink_ready;

	// One row per test with 0 for an absent factor
	typedef struct packed {
		logic [2:0] f0;
		logic [2:0] f1;
		logic [2:0] f2;
		logic [2:0] latency;
		logic       truncate;
		logic       expect_frame;
	} test_row_t;

	test_row_t tests [0:NUM_TESTS-1];

	`include "dft_mem_model.svh"

	int cyc = 0;
	int cycle_limit = 0;
	int err_cnt = 0;
	int cur_test = 0;
	int cur_lat = 1;
	int frames_done = 0;
	int out_total = 0;
	bit in_frame = 1'b0;

	// Core stand-in queues
	dft_sample_pkg::sample_t   grp_q [$];
	dft_sample_pkg::grp_beat_t ret_q [$];
	int                        ready_q [$];
	// Received output frame
	dft_sample_pkg::sample_t   rx_q [$];
	dft_sample_pkg::sample_t   frame_in [0:63];

	dft_mem_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.plan       (plan),
		.to_core    (to_core),
		.from_core  (from_core),
		.out_beat   (out_beat),
		.sink_ready (sink_ready)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int row_stages(input test_row_t r);
		return int'(r.f0 != 3'd0) + int'(r.f1 != 3'd0) + int'(r.f2 != 3'd0);
	endfunction

	function automatic int row_points(input test_row_t r);
		return ((r.f0 == 3'd0) ? 1 : int'(r.f0)) * ((r.f1 == 3'd0) ? 1 : int'(r.f1)) *
			((r.f2 == 3'd0) ? 1 : int'(r.f2));
	endfunction

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, got %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// Run limit
	// ----------------------------------------
	always @(posedge clk) begin
		cyc++;
		if (cycle_limit > 0 && cyc > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// Radix core stand-in
	// ----------------------------------------
	// Collect a group and queue it reversed after the latency
	always @(negedge clk) begin
		dft_sample_pkg::grp_beat_t rb;
		int gs;
		logic exp_first;
		if (rst_n && to_core.valid) begin
			// A group opens exactly when nothing is pending
			exp_first = (grp_q.size() == 0);
			if (to_core.first !== exp_first) begin
				$display("[ERROR] to_core.first: expected %h, got %h",
					exp_first, to_core.first);
				err_cnt++;
			end
			if (to_core.first) begin
				grp_q.delete();
			end
			grp_q.push_back(to_core.data);
			if (to_core.last) begin
				gs = grp_q.size();
				if (gs != int'(to_core.radix)) begin
					$display("Test %0d: core group of %0d beats tagged radix %0d",
						cur_test, gs, to_core.radix);
					err_cnt++;
				end
				for (int k = 0; k < gs; k++) begin
					rb.valid = 1'b1;
					rb.first = (k == 0);
					rb.last = (k == gs - 1);
					rb.radix = 3'(gs);
					rb.data = grp_q[gs - 1 - k];
					rb.data.re = rb.data.re + 16'(k + 1);
					ret_q.push_back(rb);
					ready_q.push_back(cyc + cur_lat + k);
				end
				grp_q.delete();
			end
		end
	end

	// Return one beat per cycle once due
	always @(posedge clk) begin
		#2;
		if (ready_q.size() > 0 && ready_q[0] <= cyc) begin
			from_core = ret_q.pop_front();
			void'(ready_q.pop_front());
		end else begin
			from_core = '0;
		end
	end

	// ----------------------------------------
	// Output stream monitor
	// ----------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_beat.valid) begin
				out_total++;
				if (out_beat.sop) begin
					if (in_frame) begin
						$display("Test %0d: sop inside an output frame", cur_test);
						err_cnt++;
					end
					in_frame = 1'b1;
					rx_q.delete();
				end else if (!in_frame) begin
					$display("Test %0d: valid output beat outside a frame", cur_test);
					err_cnt++;
				end
				rx_q.push_back(out_beat.data);
				if (out_beat.eop) begin
					in_frame = 1'b0;
					frames_done++;
				end
			end else if (in_frame) begin
				$display("Test %0d: gap inside an output frame", cur_test);
				err_cnt++;
			end
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int n;
		int stages;
		int n_send;
		int frames_before;
		int out_before;
		int errs_before;
		int wait_cnt;
		int addr;
		int passed;
		rst_n = 1'b0;
		in_beat = '0;
		plan = '0;
		from_core = '0;
		passed = 0;

		// f0 f1 f2, latency, truncate, expect frame
		tests[0] = '{3'd4, 3'd3, 3'd0, 3'd1, 1'b0, 1'b1};
		tests[1] = '{3'd2, 3'd2, 3'd2, 3'd3, 1'b0, 1'b1};
		tests[2] = '{3'd5, 3'd4, 3'd3, 3'd2, 1'b0, 1'b1};
		tests[3] = '{3'd3, 3'd5, 3'd0, 3'd4, 1'b0, 1'b1};
		tests[4] = '{3'd5, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1};
		tests[5] = '{3'd4, 3'd3, 3'd0, 3'd2, 1'b1, 1'b0};
		tests[6] = '{3'd4, 3'd3, 3'd0, 3'd4, 1'b0, 1'b1};

		cycle_limit = 200;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cycle_limit += 4 * row_points(tests[t]) * (row_stages(tests[t]) + 2);
		end

		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_flag("to_core.valid after reset", 1'b0, to_core.valid);
		check_flag("out_beat.valid after reset", 1'b0, out_beat.valid);
		check_flag("out_beat.sop after reset", 1'b0, out_beat.sop);
		check_flag("out_beat.eop after reset", 1'b0, out_beat.eop);
		check_flag("sink_ready after reset", 1'b1, sink_ready);

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_test = t;
			errs_before = err_cnt;
			n = row_points(tests[t]);
			stages = row_stages(tests[t]);
			cur_lat = int'(tests[t].latency);
			fac[0] = (tests[t].f0 == 3'd0) ? 1 : int'(tests[t].f0);
			fac[1] = (tests[t].f1 == 3'd0) ? 1 : int'(tests[t].f1);
			fac[2] = (tests[t].f2 == 3'd0) ? 1 : int'(tests[t].f2);

			// Next frame goes out as soon as the sink is idle
			while (sink_ready !== 1'b1) begin
				@(posedge clk);
				#2;
			end

			plan.num_factors = 2'(stages);
			plan.factor[0] = tests[t].f0;
			plan.factor[1] = tests[t].f1;
			plan.factor[2] = tests[t].f2;
			plan.n_points = dft_plan_pkg::cnt_t'(n);
			for (int i = 0; i < n; i++) begin
				frame_in[i] = draw_sample();
				model_mem[i] = frame_in[i];
			end
			apply_stages(stages);

			frames_before = frames_done;
			out_before = out_total;
			n_send = tests[t].truncate ? TRUNC_LEN : n;
			for (int i = 0; i < n_send; i++) begin
				in_beat.valid = 1'b1;
				in_beat.sop = (i == 0);
				in_beat.data = frame_in[i];
				@(posedge clk);
				#2;
				if (i == 0) begin
					check_flag("sink_ready after sop", 1'b0, sink_ready);
				end
			end
			in_beat = '0;

			if (!tests[t].expect_frame) begin
				// Stalled frame must be dropped by the watchdog
				wait_cnt = 0;
				while (sink_ready !== 1'b1 && wait_cnt < `DFT_SINK_TIMEOUT + 4) begin
					@(posedge clk);
					#2;
					wait_cnt++;
				end
				if (sink_ready !== 1'b1) begin
					$display("Test %0d: sink_ready still low %0d cycles after the stall",
						t, wait_cnt);
					err_cnt++;
				end
				if (out_total != out_before) begin
					$display("Test %0d: truncated frame produced %0d output beats",
						t, out_total - out_before);
					err_cnt++;
				end
			end else begin
				while (frames_done == frames_before) begin
					@(posedge clk);
					#2;
				end
				if (rx_q.size() != n) begin
					$display("Test %0d: output frame has %0d beats instead of %0d",
						t, rx_q.size(), n);
					err_cnt++;
				end
				for (int m = 0; m < n && m < rx_q.size(); m++) begin
					addr = out_addr(m);
					if (rx_q[m] !== model_mem[addr]) begin
						$display("[ERROR] out_beat.data[%0d]: expected %h, got %h",
							m, model_mem[addr], rx_q[m]);
						err_cnt++;
					end
				end
				check_flag("sink_ready after eop", 1'b1, sink_ready);
			end

			if (err_cnt == errs_before) begin
				passed++;
			end
			$display("Test %0d: plan %0dx%0dx%0d N=%0d latency %0d truncate %0d %s", t,
				tests[t].f0, tests[t].f1, tests[t].f2, n, cur_lat, tests[t].truncate,
				(err_cnt == errs_before) ? "ok" : "failed");
		end

		$display("%0d of %0d tests passed, %0d errors", passed, NUM_TESTS, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* hdl/dft_mem_cfg.svh */
`ifndef DFT_MEM_CFG_SVH
`define DFT_MEM_CFG_SVH

// ----------------------------------------
// Data path widths
// ----------------------------------------
// Width of each real and imaginary part
`define DFT_DATA_W 16
// Sample RAM address width, 64 words
`define DFT_ADDR_W 6

// ----------------------------------------
// Frame control limits
// ----------------------------------------
// Most radix factors in one plan
`define DFT_MAX_STAGES 3
// Idle cycles tolerated inside a partial input frame
`define DFT_SINK_TIMEOUT 64

`endif

/* hdl/dft_mem_top.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_mem_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dft_sample_pkg::in_beat_t   in_beat,
	input  dft_plan_pkg::plan_t        plan,
	output dft_sample_pkg::grp_beat_t  to_core,
	input  dft_sample_pkg::grp_beat_t  from_core,
	output dft_sample_pkg::out_beat_t  out_beat,
	output logic                       sink_ready
);

	localparam int AW = `DFT_ADDR_W;

	dft_plan_pkg::seq_state_t state;
	dft_plan_pkg::plan_t      plan_q;
	logic [1:0]               stage;
	logic                     sop_in;

	// Sub-controller handshakes
	logic                     sink_done;
	logic                     sink_timeout;
	logic                     rd_done;
	logic                     wr_done;
	logic                     src_done;

	// RAM ports and their sources
	logic                     sink_we;
	logic [AW-1:0]            sink_waddr;
	dft_sample_pkg::sample_t  sink_wdata;
	logic                     wb_we;
	logic [AW-1:0]            wb_waddr;
	dft_sample_pkg::sample_t  wb_wdata;
	logic [AW-1:0]            rd_raddr;
	logic [AW-1:0]            src_raddr;
	logic                     ram_we;
	logic [AW-1:0]            ram_waddr;
	dft_sample_pkg::sample_t  ram_wdata;
	logic [AW-1:0]            ram_raddr;
	dft_sample_pkg::sample_t  ram_rdata;

	assign sop_in = state == dft_plan_pkg::IDLE && in_beat.valid && in_beat.sop;

	// ----------------------------------------
	// Frame sequencer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= dft_plan_pkg::IDLE;
			stage <= '0;
		end else begin
			case (state)
				dft_plan_pkg::IDLE: begin
					stage <= '0;
					if (sop_in) state <= dft_plan_pkg::SINK;
				end
				dft_plan_pkg::SINK: begin
					if (sink_done) state <= dft_plan_pkg::READ;
					else if (sink_timeout) state <= dft_plan_pkg::IDLE;
				end
				dft_plan_pkg::READ: begin
					if (rd_done) state <= dft_plan_pkg::WAIT_WR;
				end
				dft_plan_pkg::WAIT_WR: begin
					// Last stage written back, frame is ready to stream
					if (wr_done && stage == plan_q.num_factors - 2'd1) begin
						state <= dft_plan_pkg::SOURCE;
					end else if (wr_done) begin
						state <= dft_plan_pkg::READ;
						stage <= stage + 2'd1;
					end
				end
				dft_plan_pkg::SOURCE: begin
					if (src_done) state <= dft_plan_pkg::IDLE;
				end
				default: state <= dft_plan_pkg::IDLE;
			endcase
		end
	end

	// Plan held for the whole frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			plan_q <= '0;
		end else if (sop_in) begin
			plan_q <= plan;
		end
	end

	assign sink_ready = state == dft_plan_pkg::IDLE;

	// ----------------------------------------
	// RAM port muxing
	// ----------------------------------------
	always_comb begin
		if (state == dft_plan_pkg::SINK) begin
			ram_we    = sink_we;
			ram_waddr = sink_waddr;
			ram_wdata = sink_wdata;
		end else begin
			ram_we    = wb_we;
			ram_waddr = wb_waddr;
			ram_wdata = wb_wdata;
		end
		ram_raddr = (state == dft_plan_pkg::SOURCE) ? src_raddr : rd_raddr;
	end

	dft_sample_ram u_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (ram_raddr),
		.rdata (ram_rdata)
	);

	dft_sink_ctrl u_sink (
		.clk          (clk),
		.rst_n        (rst_n),
		.state        (state),
		.n_points     (plan_q.n_points),
		.in_beat      (in_beat),
		.we           (sink_we),
		.waddr        (sink_waddr),
		.wdata        (sink_wdata),
		.sink_done    (sink_done),
		.sink_timeout (sink_timeout)
	);

	dft_stage_reader u_reader (
		.clk     (clk),
		.rst_n   (rst_n),
		.state   (state),
		.plan    (plan_q),
		.stage   (stage),
		.raddr   (rd_raddr),
		.rdata   (ram_rdata),
		.to_core (to_core),
		.rd_done (rd_done)
	);

	dft_stage_writer u_writer (
		.clk       (clk),
		.rst_n     (rst_n),
		.state     (state),
		.plan      (plan_q),
		.stage     (stage),
		.from_core (from_core),
		.we        (wb_we),
		.waddr     (wb_waddr),
		.wdata     (wb_wdata),
		.wr_done   (wr_done)
	);

	dft_source_ctrl u_source (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.plan     (plan_q),
		.raddr    (src_raddr),
		.rdata    (ram_rdata),
		.out_beat (out_beat),
		.src_done (src_done)
	);

	// Output stream never overlaps frame intake
	a_no_out_in_sink: assert property (@(posedge clk) disable iff (!rst_n)
		state == dft_plan_pkg::SINK |-> !out_beat.valid);

endmodule

/* hdl/dft_plan_pkg.sv */
`include "dft_mem_cfg.svh"

package dft_plan_pkg;

	// Point counters need one bit more than a RAM address
	typedef logic [`DFT_ADDR_W:0] cnt_t;

	// Frame plan, factor[0] is the first stage
	typedef struct packed {
		logic [1:0]                          num_factors;
		logic [0:`DFT_MAX_STAGES-1][2:0]     factor;
		cnt_t                                n_points;
	} plan_t;

	// Frame sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		READ,
		WAIT_WR,
		SOURCE
	} seq_state_t;

	// Radix of position i, unused positions act as radix 1
	function automatic logic [2:0] eff_factor(plan_t p, int i);
		return (i < int'(p.num_factors)) ? p.factor[i] : 3'd1;
	endfunction

	// Stride L of stage s, product of the factors after s
	function automatic cnt_t stage_stride(plan_t p, int s);
		cnt_t l;
		l = cnt_t'(1);
		for (int i = 0; i < `DFT_MAX_STAGES; i++) begin
			if (i > s) begin
				l = cnt_t'(l * cnt_t'(eff_factor(p, i)));
			end
		end
		return l;
	endfunction

endpackage

/* hdl/dft_sample_pkg.sv */
`include "dft_mem_cfg.svh"

package dft_sample_pkg;

	// Complex sample, real part in the upper half
	typedef struct packed {
		logic signed [`DFT_DATA_W-1:0] re;
		logic signed [`DFT_DATA_W-1:0] im;
	} sample_t;

	// Input stream beat, natural order
	typedef struct packed {
		logic    valid;
		logic    sop;
		sample_t data;
	} in_beat_t;

	// Output stream beat, digit-reversed order
	typedef struct packed {
		logic    valid;
		logic    sop;
		logic    eop;
		sample_t data;
	} out_beat_t;

	// Butterfly group beat, same shape to and from the radix core
	typedef struct packed {
		logic       valid;
		logic       first;
		logic       last;
		logic [2:0] radix;
		sample_t    data;
	} grp_beat_t;

endpackage

/* hdl/dft_sample_ram.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_sample_ram (
	input  logic                    clk,
	input  logic                    we,
	input  logic [`DFT_ADDR_W-1:0]  waddr,
	input  dft_sample_pkg::sample_t wdata,
	input  logic [`DFT_ADDR_W-1:0]  raddr,
	output dft_sample_pkg::sample_t rdata
);

	// One frame of samples, updated in place by every stage
	dft_sample_pkg::sample_t mem [0:(1 << `DFT_ADDR_W)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* hdl/dft_sink_ctrl.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_sink_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dft_plan_pkg::seq_state_t   state,
	input  dft_plan_pkg::cnt_t         n_points,
	input  dft_sample_pkg::in_beat_t   in_beat,
	output logic                       we,
	output logic [`DFT_ADDR_W-1:0]     waddr,
	output dft_sample_pkg::sample_t    wdata,
	output logic                       sink_done,
	output logic                       sink_timeout
);

	localparam int TO_W = $clog2(`DFT_SINK_TIMEOUT);
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(`DFT_SINK_TIMEOUT - 1);

	dft_plan_pkg::cnt_t acc_cnt;
	logic [TO_W-1:0]    idle_cnt;
	logic               take;

	// The sop beat in IDLE is sample 0 and later beats stop at a full frame
	assign take = in_beat.valid &&
		((state == dft_plan_pkg::IDLE && in_beat.sop) ||
		 (state == dft_plan_pkg::SINK && acc_cnt < n_points));

	// ----------------------------------------
	// Beat register and write address
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			we      <= 1'b0;
			acc_cnt <= '0;
		end else begin
			we <= take;
			if (take) begin
				acc_cnt <= acc_cnt + dft_plan_pkg::cnt_t'(1);
			end else if (state != dft_plan_pkg::SINK || sink_timeout) begin
				// A dropped frame leaves no stale count for the next sop
				acc_cnt <= '0;
			end
		end
	end

	// Payload and address follow the accepted beat
	always_ff @(posedge clk) begin
		if (take) begin
			wdata <= in_beat.data;
			waddr <= acc_cnt[`DFT_ADDR_W-1:0];
		end
	end

	// Pulse on the N-th write
	assign sink_done = we && ({1'b0, waddr} == n_points - dft_plan_pkg::cnt_t'(1));

	// ----------------------------------------
	// Stall watchdog
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || take || state != dft_plan_pkg::SINK) begin
			idle_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + TO_W'(1);
		end
	end

	assign sink_timeout = state == dft_plan_pkg::SINK && !take && idle_cnt == TO_LAST;

	// Sink writes never spill into the stage phases
	a_sink_write_in_sink: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> state == dft_plan_pkg::SINK);

endmodule

/* hdl/dft_source_ctrl.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_source_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dft_plan_pkg::seq_state_t   state,
	input  dft_plan_pkg::plan_t        plan,
	output logic [`DFT_ADDR_W-1:0]     raddr,
	input  dft_sample_pkg::sample_t    rdata,
	output dft_sample_pkg::out_beat_t  out_beat,
	output logic                       src_done
);

	localparam int AW = `DFT_ADDR_W;

	logic [2:0]         r0;
	logic [2:0]         r1;
	dft_plan_pkg::cnt_t w0;
	dft_plan_pkg::cnt_t w1;
	logic [2:0]         d0;
	logic [2:0]         d1;
	logic [2:0]         d2;
	logic [AW-1:0]      a0;
	logic [AW-1:0]      a1;
	dft_plan_pkg::cnt_t pt;
	logic               pt_last;
	logic               fin;
	logic               src_en;

	// Digit radices and address weights N/f0 and N/(f0*f1)
	assign r0 = dft_plan_pkg::eff_factor(plan, 0);
	assign r1 = dft_plan_pkg::eff_factor(plan, 1);
	assign w0 = dft_plan_pkg::stage_stride(plan, 0);
	assign w1 = dft_plan_pkg::stage_stride(plan, 1);

	assign pt_last = pt == plan.n_points - dft_plan_pkg::cnt_t'(1);
	assign src_en  = state == dft_plan_pkg::SOURCE && !fin;
	// d2 has weight 1
	assign raddr   = a0 + a1 + AW'(d2);

	// ----------------------------------------
	// Mixed-radix odometer, d0 fastest
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || state != dft_plan_pkg::SOURCE) begin
			d0  <= '0;
			d1  <= '0;
			d2  <= '0;
			a0  <= '0;
			a1  <= '0;
			pt  <= '0;
			fin <= 1'b0;
		end else if (src_en) begin
			pt  <= pt + dft_plan_pkg::cnt_t'(1);
			fin <= pt_last;
			if (d0 != r0 - 3'd1) begin
				d0 <= d0 + 3'd1;
				a0 <= a0 + w0[AW-1:0];
			end else begin
				d0 <= '0;
				a0 <= '0;
				if (d1 != r1 - 3'd1) begin
					d1 <= d1 + 3'd1;
					a1 <= a1 + w1[AW-1:0];
				end else begin
					// Top digit never wraps inside one frame
					d1 <= '0;
					a1 <= '0;
					d2 <= d2 + 3'd1;
				end
			end
		end
	end

	// ----------------------------------------
	// Flags delayed two cycles to meet the data
	// ----------------------------------------
	logic                    v1;
	logic                    s1;
	logic                    e1;
	logic                    out_vld;
	logic                    out_sop;
	logic                    out_eop;
	dft_sample_pkg::sample_t out_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1      <= 1'b0;
			s1      <= 1'b0;
			e1      <= 1'b0;
			out_vld <= 1'b0;
			out_sop <= 1'b0;
			out_eop <= 1'b0;
		end else begin
			v1      <= src_en;
			s1      <= src_en && pt == '0;
			e1      <= src_en && pt_last;
			out_vld <= v1;
			out_sop <= s1;
			out_eop <= e1;
		end
	end

	// Output sample register after the RAM read register
	always_ff @(posedge clk) begin
		out_data <= rdata;
	end

	assign out_beat = '{valid: out_vld, sop: out_sop, eop: out_eop, data: out_data};
	assign src_done = out_vld && out_eop;

endmodule

/* hdl/dft_stage_reader.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_stage_reader (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dft_plan_pkg::seq_state_t   state,
	input  dft_plan_pkg::plan_t        plan,
	input  logic [1:0]                 stage,
	output logic [`DFT_ADDR_W-1:0]     raddr,
	input  dft_sample_pkg::sample_t    rdata,
	output dft_sample_pkg::grp_beat_t  to_core,
	output logic                       rd_done
);

	localparam int AW = `DFT_ADDR_W;

	logic [2:0]         fs;
	dft_plan_pkg::cnt_t stride;
	logic [2:0]         k;
	dft_plan_pkg::cnt_t j;
	logic [AW-1:0]      base;
	logic [AW-1:0]      addr;
	dft_plan_pkg::cnt_t pt;
	logic               pt_last;
	logic               fin;
	logic               rd_en;

	// Radix and stride of this stage
	assign fs     = plan.factor[stage];
	assign stride = dft_plan_pkg::stage_stride(plan, int'(stage));

	assign pt_last = pt == plan.n_points - dft_plan_pkg::cnt_t'(1);
	assign rd_en   = state == dft_plan_pkg::READ && !fin;
	assign raddr   = addr;

	// ----------------------------------------
	// Group address counters
	// ----------------------------------------
	// k inner, j across groups of one block, blocks follow
	always_ff @(posedge clk) begin
		if (!rst_n || state != dft_plan_pkg::READ || (rd_en && pt_last)) begin
			k    <= '0;
			j    <= '0;
			base <= '0;
			addr <= '0;
			pt   <= '0;
		end else if (rd_en) begin
			pt <= pt + dft_plan_pkg::cnt_t'(1);
			if (k != fs - 3'd1) begin
				k    <= k + 3'd1;
				addr <= addr + stride[AW-1:0];
			end else begin
				k <= '0;
				if (j != stride - dft_plan_pkg::cnt_t'(1)) begin
					// Next group in the same block
					j    <= j + dft_plan_pkg::cnt_t'(1);
					base <= base + AW'(1);
					addr <= base + AW'(1);
				end else begin
					// Next block starts right after the last point
					j    <= '0;
					base <= addr + AW'(1);
					addr <= addr + AW'(1);
				end
			end
		end
	end

	// Stop issuing once N addresses went out
	always_ff @(posedge clk) begin
		if (!rst_n || state != dft_plan_pkg::READ) begin
			fin <= 1'b0;
		end else if (rd_en && pt_last) begin
			fin <= 1'b1;
		end
	end

	// ----------------------------------------
	// Tags aligned with the RAM latency
	// ----------------------------------------
	logic       tag_vld;
	logic       tag_first;
	logic       tag_last;
	logic [2:0] tag_radix;
	logic       tag_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_vld   <= 1'b0;
			tag_first <= 1'b0;
			tag_last  <= 1'b0;
			tag_radix <= '0;
			tag_end   <= 1'b0;
		end else begin
			tag_vld   <= rd_en;
			tag_first <= rd_en && k == 3'd0;
			tag_last  <= rd_en && k == fs - 3'd1;
			tag_radix <= fs;
			tag_end   <= rd_en && pt_last;
		end
	end

	assign to_core = '{valid: tag_vld, first: tag_first, last: tag_last,
		radix: tag_radix, data: rdata};
	assign rd_done = tag_vld && tag_end;

	// Read addresses stay inside the captured frame
	a_raddr_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> {1'b0, raddr} < plan.n_points);

endmodule

/* hdl/dft_stage_writer.sv */
`timescale 1ns/10ps
`include "dft_mem_cfg.svh"

module dft_stage_writer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dft_plan_pkg::seq_state_t   state,
	input  dft_plan_pkg::plan_t        plan,
	input  logic [1:0]                 stage,
	input  dft_sample_pkg::grp_beat_t  from_core,
	output logic                       we,
	output logic [`DFT_ADDR_W-1:0]     waddr,
	output dft_sample_pkg::sample_t    wdata,
	output logic                       wr_done
);

	localparam int AW = `DFT_ADDR_W;

	logic [2:0]         fs;
	dft_plan_pkg::cnt_t stride;
	logic [2:0]         k;
	dft_plan_pkg::cnt_t j;
	logic [AW-1:0]      base;
	logic [AW-1:0]      addr;
	dft_plan_pkg::cnt_t pt;
	logic               pt_last;
	logic               busy;
	logic               wr_last;

	assign fs      = plan.factor[stage];
	assign stride  = dft_plan_pkg::stage_stride(plan, int'(stage));
	assign pt_last = pt == plan.n_points - dft_plan_pkg::cnt_t'(1);
	assign busy    = state == dft_plan_pkg::READ || state == dft_plan_pkg::WAIT_WR;

	// Same walk as the reader, one step per returned beat
	always_ff @(posedge clk) begin
		if (!rst_n || !busy || (from_core.valid && pt_last)) begin
			k    <= '0;
			j    <= '0;
			base <= '0;
			addr <= '0;
			pt   <= '0;
		end else if (from_core.valid) begin
			pt <= pt + dft_plan_pkg::cnt_t'(1);
			if (k != fs - 3'd1) begin
				k    <= k + 3'd1;
				addr <= addr + stride[AW-1:0];
			end else begin
				k <= '0;
				if (j != stride - dft_plan_pkg::cnt_t'(1)) begin
					j    <= j + dft_plan_pkg::cnt_t'(1);
					base <= base + AW'(1);
					addr <= base + AW'(1);
				end else begin
					j    <= '0;
					base <= addr + AW'(1);
					addr <= addr + AW'(1);
				end
			end
		end
	end

	// ----------------------------------------
	// Write-back register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			we      <= 1'b0;
			wr_last <= 1'b0;
		end else begin
			we      <= from_core.valid && busy;
			wr_last <= from_core.valid && pt_last;
		end
	end

	always_ff @(posedge clk) begin
		waddr <= addr;
		wdata <= from_core.data;
	end

	assign wr_done = we && wr_last;

	// Core returns exactly N beats per stage
	a_no_extra_core_beat: assert property (@(posedge clk) disable iff (!rst_n)
		from_core.valid |-> busy && !wr_done);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the DFT sample memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module dft_mem_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vdft_mem_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+hdl
+incdir+bench
hdl/dft_sample_pkg.sv
hdl/dft_plan_pkg.sv
hdl/dft_sample_ram.sv
hdl/dft_sink_ctrl.sv
hdl/dft_stage_reader.sv
hdl/dft_stage_writer.sv
hdl/dft_source_ctrl.sv
hdl/dft_mem_top.sv
bench/dft_mem_tb.sv
